// ==== Bender.yml ====
package:
  name: fht

sources:
  - common/fht_pkg.sv
  - fht/fht_bfly.sv
  - fht/fht4_core.sv
  - source/fht_scale.sv
  - source/fht_cfg_regs.sv
  - source/fht_top.sv
  - target: simulation
    files:
      - testbench/fht_asserts.sv
      - testbench/fht_tb.sv

// ==== common/fht_pkg.sv ====
/*
 * fht shared definitions
 * sample and coefficient widths, frame structs, scale type
 * and the configuration register map
 */

package fht_pkg;

	// input sample width
	localparam int SAMPLE_W = 12;

	// two butterfly stages, one bit of growth each
	localparam int COEF_W = SAMPLE_W + 2;

	// config bus data width
	localparam int CFG_DATA_W = 16;

	// register addresses
	// ctrl: bit 0 enable, bits 2:1 scale
	localparam logic [1:0] CFG_ADDR_CTRL  = 2'd0;
	// count: produced frames, read only
	localparam logic [1:0] CFG_ADDR_COUNT = 2'd1;

	// output right-shift, legal 0..2
	// 2 gives the inverse transform (1/N with N = 4)
	typedef logic [1:0] scale_t;

	// one input frame of four samples
	typedef struct packed
	{
		logic signed [SAMPLE_W-1:0] x0;
		logic signed [SAMPLE_W-1:0] x1;
		logic signed [SAMPLE_W-1:0] x2;
		logic signed [SAMPLE_W-1:0] x3;
	} sample_frame_t;

	// one output frame of four hartley coefficients
	typedef struct packed
	{
		logic signed [COEF_W-1:0] h0;
		logic signed [COEF_W-1:0] h1;
		logic signed [COEF_W-1:0] h2;
		logic signed [COEF_W-1:0] h3;
	} coef_frame_t;

endpackage

// ==== fht/fht4_core.sv ====
/*
 * four-point hartley core
 * two stages of butterflies in the crossed hartley order,
 * frames gated by enable, two frames in flight at most
 */

module fht4_core (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   enable,
	input  logic                   in_valid,
	input  fht_pkg::sample_frame_t in_frame,
	output logic                   core_valid,
	output fht_pkg::coef_frame_t   core_frame
);

	// stage one strobe
	logic v1;
	// stage two strobe, one cycle behind
	logic v2_q;

	// stage one outputs
	logic signed [fht_pkg::SAMPLE_W:0] s0;
	logic signed [fht_pkg::SAMPLE_W:0] s1;
	logic signed [fht_pkg::SAMPLE_W:0] d0;
	logic signed [fht_pkg::SAMPLE_W:0] d1;

	// frames dropped while disabled
	assign v1 = in_valid & enable;

	// valid pipeline matches the butterfly registers
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			v2_q       <= 1'b0;
			core_valid <= 1'b0;
		end
		else
		begin
			v2_q       <= v1;
			core_valid <= v2_q;
		end
	end

	// stage one: x0 with x2
	fht_bfly #(.N(fht_pkg::SAMPLE_W)) u_bfly_s1_0 (
		.clk   (clk),
		.rstn  (rstn),
		.valid (v1),
		.a     (in_frame.x0),
		.b     (in_frame.x2),
		.c     (s0),
		.d     (d0)
	);

	// stage one: x1 with x3
	fht_bfly #(.N(fht_pkg::SAMPLE_W)) u_bfly_s1_1 (
		.clk   (clk),
		.rstn  (rstn),
		.valid (v1),
		.a     (in_frame.x1),
		.b     (in_frame.x3),
		.c     (s1),
		.d     (d1)
	);

	// stage two: sums give h0 and h2
	fht_bfly #(.N(fht_pkg::SAMPLE_W + 1)) u_bfly_s2_0 (
		.clk   (clk),
		.rstn  (rstn),
		.valid (v2_q),
		.a     (s0),
		.b     (s1),
		.c     (core_frame.h0),
		.d     (core_frame.h2)
	);

	// stage two: differences give h1 and h3
	fht_bfly #(.N(fht_pkg::SAMPLE_W + 1)) u_bfly_s2_1 (
		.clk   (clk),
		.rstn  (rstn),
		.valid (v2_q),
		.a     (d0),
		.b     (d1),
		.c     (core_frame.h1),
		.d     (core_frame.h3)
	);

endmodule

// ==== fht/fht_bfly.sv ====
/*
 * fht butterfly
 * registers two operands on valid, then gives their exact
 * sum and difference one bit wider through a ripple adder
 */

module fht_bfly #(
	parameter int N = 8
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                valid,
	input  logic signed [N-1:0] a,
	input  logic signed [N-1:0] b,
	output logic signed [N:0]   c,
	output logic signed [N:0]   d
);

	// operand registers
	logic signed [N-1:0] a_q;
	logic signed [N-1:0] b_q;

	// sign-extended operands
	logic [N:0] a_ext;
	logic [N:0] b_ext;

	// half adder, returns {carry, sum}
	function automatic logic [1:0] half_adder(input logic x, input logic y);
		half_adder = {x & y, x ^ y};
	endfunction

	// full adder out of two half adders
	function automatic logic [1:0] full_adder(input logic x, input logic y, input logic ci);
		logic [1:0] h1;
		logic [1:0] h2;
		h1 = half_adder(x, y);
		h2 = half_adder(h1[0], ci);
		full_adder = {h1[1] | h2[1], h2[0]};
	endfunction

	// ripple carry adder over N+1 bits
	// carry out dropped, operands already sign-extended so no overflow
	function automatic logic [N:0] rca(input logic [N:0] x, input logic [N:0] y,
		input logic ci);
		logic       carry;
		logic [1:0] fa;
		carry = ci;
		for (int i = 0; i <= N; i++)
		begin
			fa     = full_adder(x[i], y[i], carry);
			rca[i] = fa[0];
			carry  = fa[1];
		end
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			a_q <= '0;
			b_q <= '0;
		end
		else if (valid)
		begin
			a_q <= a;
			b_q <= b;
		end
	end

	assign a_ext = {a_q[N-1], a_q};
	assign b_ext = {b_q[N-1], b_q};

	// a + b
	assign c = rca(a_ext, b_ext, 1'b0);
	// a - b as a + ~b + 1, exact even for the most negative b
	assign d = rca(a_ext, ~b_ext, 1'b1);

endmodule

// ==== sim.f ====
common/fht_pkg.sv
fht/fht_bfly.sv
fht/fht4_core.sv
source/fht_scale.sv
source/fht_cfg_regs.sv
source/fht_top.sv
testbench/fht_asserts.sv
testbench/fht_tb.sv

// ==== source/fht_cfg_regs.sv ====
/*
 * configuration registers
 * enable and scale in ctrl, read-only frame counter
 */

module fht_cfg_regs (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           cfg_we,
	input  logic [1:0]                     cfg_addr,
	input  logic [fht_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic [fht_pkg::CFG_DATA_W-1:0] cfg_rdata,
	input  logic                           out_valid,
	output logic                           enable,
	output fht_pkg::scale_t                scale
);

	// produced frames, wraps
	logic [fht_pkg::CFG_DATA_W-1:0] frame_cnt;

	// scale field from the write data
	fht_pkg::scale_t wr_scale;

	// 3 is not legal, clamp to 2
	assign wr_scale = (cfg_wdata[2:1] == 2'd3) ? 2'd2 : cfg_wdata[2:1];

	// ctrl write, count writes ignored
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			enable <= 1'b0;
			scale  <= '0;
		end
		else if (cfg_we && cfg_addr == fht_pkg::CFG_ADDR_CTRL)
		begin
			enable <= cfg_wdata[0];
			scale  <= wr_scale;
		end
	end

	// one count per out_valid pulse
	always_ff @(posedge clk)
	begin
		if (!rstn)
			frame_cnt <= '0;
		else if (out_valid)
			frame_cnt <= frame_cnt + 1'b1;
	end

	// read mux, unmapped addresses read 0
	always_comb
	begin
		case (cfg_addr)
			fht_pkg::CFG_ADDR_CTRL:  cfg_rdata = {{(fht_pkg::CFG_DATA_W-3){1'b0}}, scale, enable};
			fht_pkg::CFG_ADDR_COUNT: cfg_rdata = frame_cnt;
			default:                 cfg_rdata = '0;
		endcase
	end

endmodule

// ==== source/fht_scale.sv ====
/*
 * output scaler
 * registers each coefficient shifted right arithmetically,
 * scale 2 gives the inverse transform
 */

module fht_scale (
	input  logic                 clk,
	input  logic                 rstn,
	input  fht_pkg::scale_t      scale,
	input  logic                 core_valid,
	input  fht_pkg::coef_frame_t core_frame,
	output logic                 out_valid,
	output fht_pkg::coef_frame_t out_frame
);

	// shifted frame, combinational
	fht_pkg::coef_frame_t shifted;

	// >>> on signed fields, truncates toward minus infinity
	always_comb
	begin
		shifted.h0 = core_frame.h0 >>> scale;
		shifted.h1 = core_frame.h1 >>> scale;
		shifted.h2 = core_frame.h2 >>> scale;
		shifted.h3 = core_frame.h3 >>> scale;
	end

	// scale taken when the frame passes here
	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			out_frame <= '0;
		end
		else if (core_valid)
		begin
			out_frame <= shifted;
		end
	end

	// one-cycle pulse per frame, back to back allowed
	always_ff @(posedge clk)
	begin
		if (!rstn)
			out_valid <= 1'b0;
		else
			out_valid <= core_valid;
	end

endmodule

// ==== source/fht_top.sv ====
/*
 * four-point fht engine
 * config block, hartley core and output scaler, latency 3
 */

module fht_top (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           in_valid,
	input  fht_pkg::sample_frame_t         in_frame,
	output logic                           out_valid,
	output fht_pkg::coef_frame_t           out_frame,
	input  logic                           cfg_we,
	input  logic [1:0]                     cfg_addr,
	input  logic [fht_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic [fht_pkg::CFG_DATA_W-1:0] cfg_rdata
);

	// config to datapath
	logic            enable;
	fht_pkg::scale_t scale;

	// core to scaler
	logic                 core_valid;
	fht_pkg::coef_frame_t core_frame;

	// counter sees the same out_valid as the outside
	fht_cfg_regs u_cfg (
		.clk       (clk),
		.rstn      (rstn),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.out_valid (out_valid),
		.enable    (enable),
		.scale     (scale)
	);

	// two butterfly stages
	fht4_core u_core (
		.clk        (clk),
		.rstn       (rstn),
		.enable     (enable),
		.in_valid   (in_valid),
		.in_frame   (in_frame),
		.core_valid (core_valid),
		.core_frame (core_frame)
	);

	// output register with shift
	fht_scale u_scale (
		.clk        (clk),
		.rstn       (rstn),
		.scale      (scale),
		.core_valid (core_valid),
		.core_frame (core_frame),
		.out_valid  (out_valid),
		.out_frame  (out_frame)
	);

endmodule

// ==== testbench/fht_asserts.sv ====
/*
 * fht top level properties
 * latency of 3, quiet output in reset, coefficient range
 */

module fht_asserts (
	input logic                 clk,
	input logic                 rstn,
	input logic                 in_valid,
	input logic                 enable,
	input logic                 out_valid,
	input fht_pkg::coef_frame_t out_frame
);
	timeunit 1ns;
	timeprecision 100ps;

	// h0 adds all four samples
	localparam int H0_MIN = -4 * (2 ** (fht_pkg::SAMPLE_W - 1));
	localparam int H0_MAX = 4 * (2 ** (fht_pkg::SAMPLE_W - 1) - 1);
	// h1 to h3 subtract two samples and so stay symmetric
	localparam int HX_LIM = 4 * (2 ** (fht_pkg::SAMPLE_W - 1)) - 2;

	// failed assertions so far
	int fail_cnt = 0;

	function automatic logic in_range(input logic signed [fht_pkg::COEF_W-1:0] h,
		input int lo, input int hi);
		return (int'(h) >= lo) && (int'(h) <= hi);
	endfunction

	// accepted frame leaves exactly 3 cycles later
	latency_a: assert property (@(posedge clk) disable iff (!rstn)
		(in_valid && enable) |-> ##3 out_valid)
	else
	begin
		fail_cnt++;
		$error("out_valid missing 3 cycles after an accepted frame");
	end

	// and no pulse without such a frame
	origin_a: assert property (@(posedge clk) disable iff (!rstn)
		out_valid |-> $past(in_valid && enable, 3))
	else
	begin
		fail_cnt++;
		$error("out_valid without an accepted frame 3 cycles before");
	end

	reset_a: assert property (@(posedge clk) !rstn |=> !out_valid)
	else
	begin
		fail_cnt++;
		$error("out_valid high after a reset edge");
	end

	range_a: assert property (@(posedge clk) disable iff (!rstn)
		out_valid |-> (in_range(out_frame.h0, H0_MIN, H0_MAX) &&
		in_range(out_frame.h1, -HX_LIM, HX_LIM) &&
		in_range(out_frame.h2, -HX_LIM, HX_LIM) &&
		in_range(out_frame.h3, -HX_LIM, HX_LIM)))
	else
	begin
		fail_cnt++;
		$error("output coefficient out of range");
	end

endmodule

bind fht_top fht_asserts u_asserts (
	.clk       (clk),
	.rstn      (rstn),
	.in_valid  (in_valid),
	.enable    (enable),
	.out_valid (out_valid),
	.out_frame (out_frame)
);

// ==== testbench/fht_tb.sv ====
/*
 * fht engine testbench
 * random and extreme frames through fht_top, checked against a
 * hartley reference model, plus config and counter checks
 */

module fht_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// frames per test that also set the timeout
	localparam int N_RAND   = 40;
	localparam int N_EXT    = 8;
	localparam int N_SCALED = 16;
	localparam int N_BURST  = 24;
	localparam int N_OFF    = 8;
	localparam int TIMEOUT  = N_RAND + N_EXT + 2 * N_SCALED + N_BURST + N_OFF + 100;
	localparam int SMIN     = -(2 ** (fht_pkg::SAMPLE_W - 1));
	localparam int SMAX     = 2 ** (fht_pkg::SAMPLE_W - 1) - 1;

	logic                           clk;
	logic                           rstn;
	logic                           in_valid;
	fht_pkg::sample_frame_t         in_frame;
	logic                           out_valid;
	fht_pkg::coef_frame_t           out_frame;
	logic                           cfg_we;
	logic [1:0]                     cfg_addr;
	logic [fht_pkg::CFG_DATA_W-1:0] cfg_wdata;
	logic [fht_pkg::CFG_DATA_W-1:0] cfg_rdata;

	// expected frames and the cycle each one is due
	fht_pkg::coef_frame_t exp_q[$];
	int                   due_q[$];
	int                   cycle;
	int                   obs_cnt;
	// shadow of ctrl as written
	logic                 tb_enable;
	fht_pkg::scale_t      tb_scale;

	fht_top uut (.*);

	always #4 clk = ~clk;

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	// kernel signs of the four-point hartley transform and then the shift
	function automatic fht_pkg::coef_frame_t hartley_ref(input fht_pkg::sample_frame_t f,
		input fht_pkg::scale_t s);
		int x0;
		int x1;
		int x2;
		int x3;
		fht_pkg::coef_frame_t r;
		x0 = f.x0;
		x1 = f.x1;
		x2 = f.x2;
		x3 = f.x3;
		r.h0 = (x0 + x1 + x2 + x3) >>> s;
		r.h1 = (x0 + x1 - x2 - x3) >>> s;
		r.h2 = (x0 - x1 + x2 - x3) >>> s;
		r.h3 = (x0 - x1 - x2 + x3) >>> s;
		return r;
	endfunction

	function automatic fht_pkg::sample_frame_t make_frame(input int a, b, c, d);
		fht_pkg::sample_frame_t f;
		f.x0 = a;
		f.x1 = b;
		f.x2 = c;
		f.x3 = d;
		return f;
	endfunction

	function automatic fht_pkg::sample_frame_t random_frame();
		return make_frame($urandom, $urandom, $urandom, $urandom);
	endfunction

	// one write cycle and the ctrl shadow with scale 3 clamped to 2
	task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		if (addr == fht_pkg::CFG_ADDR_CTRL)
		begin
			tb_enable = data[0];
			tb_scale  = (data[2:1] == 2'd3) ? 2'd2 : data[2:1];
		end
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	// rdata is combinational and sampled mid cycle
	task automatic check_cfg(input logic [1:0] addr, input logic [15:0] want);
		@(posedge clk);
		#1;
		cfg_addr = addr;
		@(negedge clk);
		assert (cfg_rdata == want)
		else report_fail($sformatf("FAILED cfg_rdata addr %h got %h expected %h",
			addr, cfg_rdata, want));
	endtask

	// in_valid stays high until go_idle
	task automatic send_frame(input fht_pkg::sample_frame_t f);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_frame = f;
		if (tb_enable)
		begin
			exp_q.push_back(hartley_ref(f, tb_scale));
			due_q.push_back(cycle + 3);
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_frame = random_frame();
	endtask

	// wait until every expected frame has come out
	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	// cycle count and timeout
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		assert (cycle < TIMEOUT)
		else report_fail("timeout: the run did not finish within the cycle limit");
	end

	// outputs are registered and stable at the falling edge
	always @(negedge clk)
	begin
		fht_pkg::coef_frame_t want;
		int due;
		assert (uut.u_asserts.fail_cnt == 0)
		else report_fail("a concurrent assertion on fht_top failed");
		if (rstn && out_valid)
		begin
			assert (exp_q.size() != 0)
			else report_fail("out_valid seen while no frame was expected");
			want = exp_q.pop_front();
			due  = due_q.pop_front();
			assert (cycle == due)
			else report_fail($sformatf("frame came out at cycle %0d but was due at cycle %0d",
				cycle, due));
			assert (out_frame == want)
			else report_fail($sformatf("FAILED out_frame got %h expected %h", out_frame, want));
			obs_cnt++;
		end
	end

	initial
	begin
		clk       = 1'b0;
		rstn      = 1'b0;
		in_valid  = 1'b0;
		in_frame  = '0;
		cfg_we    = 1'b0;
		cfg_addr  = fht_pkg::CFG_ADDR_CTRL;
		cfg_wdata = '0;
		cycle     = 0;
		obs_cnt   = 0;
		tb_enable = 1'b0;
		tb_scale  = '0;
		void'($urandom(32'h71bcc5ea));
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;

		// reset state
		assert (out_valid == 1'b0)
		else report_fail($sformatf("FAILED out_valid after reset got %h expected 0", out_valid));
		check_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0000);
		check_cfg(fht_pkg::CFG_ADDR_COUNT, 16'h0000);

		// random frames at scale 0
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0001);
		repeat (N_RAND) send_frame(random_frame());
		go_idle();
		drain();

		// extreme frames where all minimum needs the exact difference
		send_frame(make_frame(SMIN, SMIN, SMIN, SMIN));
		send_frame(make_frame(SMAX, SMAX, SMAX, SMAX));
		send_frame(make_frame(SMAX, SMIN, SMAX, SMIN));
		send_frame(make_frame(SMIN, SMAX, SMIN, SMAX));
		send_frame(make_frame(SMAX, SMAX, SMIN, SMIN));
		send_frame(make_frame(SMIN, SMIN, SMAX, SMAX));
		send_frame(make_frame(SMAX, SMIN, SMIN, SMAX));
		send_frame(make_frame(SMIN, SMAX, SMAX, SMIN));
		go_idle();
		drain();

		// scale 1 then 2 written with the pipeline empty
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0003);
		repeat (N_SCALED) send_frame(random_frame());
		go_idle();
		drain();
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0005);
		repeat (N_SCALED) send_frame(random_frame());
		go_idle();
		drain();
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0007);
		check_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0005);

		// back-to-back burst and then frames while disabled
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0001);
		repeat (N_BURST) send_frame(random_frame());
		go_idle();
		drain();
		write_cfg(fht_pkg::CFG_ADDR_CTRL, 16'h0000);
		repeat (N_OFF) send_frame(random_frame());
		go_idle();
		repeat (6) @(posedge clk);

		// counter against the pulses seen here
		check_cfg(fht_pkg::CFG_ADDR_COUNT, obs_cnt[15:0]);

		if (exp_q.size() == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
			report_fail("frames were still expected at the end of the run");
	end

endmodule
